// File: verilog/msoc_periph_pkg.sv
// Peripheral subsystem definitions
// Bus widths, region map, UART register offsets and the shared
// UART state encoding used by the bridge, UART and FIFO blocks.

package msoc_periph_pkg;

  // bus side
  typedef logic [31:0] addr_t;                  // byte address
  typedef logic [31:0] data_t;                  // bus data word
  typedef logic [3:0]  strb_t;                  // byte strobes
  typedef logic [1:0]  resp_t;                  // AXI response

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // address map, region in addr[23:20], word offset in addr[5:2]
  typedef logic [3:0] region_t;
  typedef logic [3:0] reg_off_t;

  localparam region_t REGION_UART_CTRL = 4'd2;
  localparam region_t REGION_UART_RX   = 4'd3;
  localparam region_t REGION_BOARD     = 4'd7;

  localparam reg_off_t OFF_TX_BYTE = 4'd0;
  localparam reg_off_t OFF_BAUD    = 4'd1;
  localparam reg_off_t OFF_BREAK   = 4'd2;

  // UART
  typedef logic [7:0]  uart_byte_t;
  typedef logic [15:0] baud_t;                  // clocks per bit

  localparam baud_t BAUD_RESET = 16'd87;

  // receive FIFO
  typedef logic [11:0] fifo_cnt_t;
  typedef logic [8:0]  rx_entry_t;              // {frame error, byte}

  localparam int        RX_FIFO_DEPTH  = 16;
  localparam fifo_cnt_t RX_ALMOST_FULL = 12'd14;

  // board I/O
  typedef logic [7:0]  led_t;
  typedef logic [15:0] dip_t;

  typedef enum logic [1:0] {
    IDLE,
    START,
    DATA,
    STOP
  } uart_state_t;

endpackage

// File: verilog/sync_fifo.sv
// Single-clock FIFO with first-word fall-through
// Reports empty, full and almost-full, the occupancy count and sticky
// overflow and underflow flags.

`timescale 1ns/1ps

module sync_fifo
  import msoc_periph_pkg::*;
#(
  parameter int DEPTH = RX_FIFO_DEPTH
)
(
  input  logic      msoc_clk,
  input  logic      rstn,
  input  logic      push_i,
  input  rx_entry_t din_i,
  input  logic      pop_i,
  output rx_entry_t dout_o,
  output logic      empty_o,
  output logic      full_o,
  output logic      almost_full_o,
  output fifo_cnt_t count_o,
  output logic      wrerr_o,
  output logic      rderr_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  rx_entry_t        mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  fifo_cnt_t        count;
  logic             do_push;
  logic             do_pop;

  assign empty_o       = (count == '0);
  assign full_o        = (count == fifo_cnt_t'(DEPTH));
  assign almost_full_o = (count >= RX_ALMOST_FULL);
  assign count_o       = count;
  assign dout_o        = mem[rd_ptr];                // head entry

  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      wrerr_o <= 1'b0;
      rderr_o <= 1'b0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (do_push & ~do_pop)
        count <= count + 12'd1;
      else if (do_pop & ~do_push)
        count <= count - 12'd1;
      if (push_i & full_o)
        wrerr_o <= 1'b1;                             // sticky until reset
      if (pop_i & empty_o)
        rderr_o <= 1'b1;
    end
  end

  always_ff @(posedge msoc_clk)
  begin
    if (do_push)
      mem[wr_ptr] <= din_i;
  end

endmodule

// File: verilog/uart_core.sv
// UART line engine, 8N1
// Transmit and receive state machines with per-bit baud counters.
// The receive line is cleaned by a 3-sample majority filter and each
// bit is sampled near its middle.

`timescale 1ns/1ps

module uart_core
  import msoc_periph_pkg::*;
(
  input  logic       msoc_clk,
  input  logic       rstn,
  input  logic       tx_start_i,
  input  uart_byte_t tx_byte_i,
  input  baud_t      baud_i,
  input  logic       break_i,
  input  logic       rx_i,
  output logic       tx_o,
  output logic       tx_busy_o,
  output logic       rx_valid_o,
  output uart_byte_t rx_byte_o,
  output logic       rx_err_o,
  output logic       rx_busy_o
);

  uart_state_t tx_state;
  baud_t       tx_cnt;
  logic [2:0]  tx_idx;
  uart_byte_t  tx_shift;
  logic        tx_line;
  uart_state_t rx_state;
  baud_t       rx_cnt;
  logic [2:0]  rx_idx;
  uart_byte_t  rx_shift;
  logic [2:0]  rx_samp;
  logic        rx_maj;

  //////////////////////////////////////////////////////////////////////
  // transmit

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      tx_state <= IDLE;
      tx_cnt   <= '0;
      tx_idx   <= '0;
    end
    else if (tx_state == IDLE)
    begin
      if (tx_start_i)
      begin
        tx_state <= START;
        tx_cnt   <= baud_i - 16'd1;
      end
    end
    else if (tx_cnt != '0)
      tx_cnt <= tx_cnt - 16'd1;
    else
    begin
      tx_cnt <= baud_i - 16'd1;                      // next bit period
      case (tx_state)
        START:
        begin
          tx_state <= DATA;
          tx_idx   <= '0;
        end
        DATA:
          if (tx_idx == 3'd7)
            tx_state <= STOP;
          else
            tx_idx <= tx_idx + 3'd1;
        default: tx_state <= IDLE;                   // end of stop bit
      endcase
    end
  end

  always_ff @(posedge msoc_clk)
  begin
    if ((tx_state == IDLE) && tx_start_i)
      tx_shift <= tx_byte_i;
    else if ((tx_state == DATA) && (tx_cnt == '0))
      tx_shift <= tx_shift >> 1;                     // lsb first
  end

  always_comb
  begin
    case (tx_state)
      START:   tx_line = 1'b0;
      DATA:    tx_line = tx_shift[0];
      default: tx_line = 1'b1;
    endcase
  end

  assign tx_o      = tx_line & ~break_i;             // break holds line low
  assign tx_busy_o = (tx_state != IDLE);

  //////////////////////////////////////////////////////////////////////
  // receive

  assign rx_maj = (rx_samp[0] & rx_samp[1]) | (rx_samp[0] & rx_samp[2]) |
                  (rx_samp[1] & rx_samp[2]);

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      rx_samp    <= 3'b111;                          // idle line
      rx_state   <= IDLE;
      rx_cnt     <= '0;
      rx_idx     <= '0;
      rx_valid_o <= 1'b0;
      rx_err_o   <= 1'b0;
    end
    else
    begin
      rx_samp <= {rx_samp[1:0], rx_i};
      if (rx_state == IDLE)
      begin
        if (!rx_maj)
        begin
          rx_state   <= START;
          rx_cnt     <= baud_i >> 1;                 // half a bit to the middle
          rx_valid_o <= 1'b0;
        end
      end
      else if (rx_cnt != '0)
        rx_cnt <= rx_cnt - 16'd1;
      else
      begin
        rx_cnt <= baud_i - 16'd1;
        case (rx_state)
          START:
            if (!rx_maj)
            begin
              rx_state <= DATA;
              rx_idx   <= '0;
            end
            else
              rx_state <= IDLE;                      // glitch, not a start bit
          DATA:
            if (rx_idx == 3'd7)
              rx_state <= STOP;
            else
              rx_idx <= rx_idx + 3'd1;
          default:
          begin
            rx_err_o   <= ~rx_maj;                   // stop bit must be one
            rx_valid_o <= 1'b1;
            rx_state   <= IDLE;
          end
        endcase
      end
    end
  end

  always_ff @(posedge msoc_clk)
  begin
    if ((rx_state == DATA) && (rx_cnt == '0))
      rx_shift <= {rx_maj, rx_shift[7:1]};
  end

  assign rx_byte_o = rx_shift;
  assign rx_busy_o = (rx_state != IDLE);

endmodule

// File: verilog/uart_regs.sv
// UART register block
// Holds the transmit byte, baud divisor and break control, pushes each
// received byte into the receive FIFO and builds the status word.

`timescale 1ns/1ps

module uart_regs
  import msoc_periph_pkg::*;
(
  input  logic      msoc_clk,
  input  logic      rstn,
  input  logic      reg_we_i,
  input  region_t   reg_region_i,
  input  reg_off_t  reg_off_i,
  input  data_t     reg_wdata_i,
  output data_t     rdata_o,
  output logic      rx_push_o,
  output rx_entry_t rx_entry_o,
  input  rx_entry_t rx_head_i,
  input  logic      rx_empty_i,
  input  logic      rx_full_i,
  input  logic      rx_almost_full_i,
  input  logic      rx_wrerr_i,
  input  logic      rx_rderr_i,
  input  fifo_cnt_t rx_count_i,
  input  logic      uart_rx_i,
  output logic      uart_tx_o,
  output logic      u_break_o
);

  uart_byte_t tx_byte_q;
  baud_t      baud_q;
  logic       tx_start_q;
  logic       ctrl_we;
  logic       rx_valid;
  logic       rx_valid_q;
  logic       rx_err;
  uart_byte_t rx_byte;
  logic       tx_busy;
  logic       rx_busy;
  data_t      status_word;
  data_t      ctrl_word;

  assign ctrl_we = reg_we_i & (reg_region_i == REGION_UART_CTRL);

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      baud_q     <= BAUD_RESET;
      u_break_o  <= 1'b0;
      tx_start_q <= 1'b0;
      rx_valid_q <= 1'b0;
    end
    else
    begin
      tx_start_q <= ctrl_we & (reg_off_i == OFF_TX_BYTE);  // one cycle
      rx_valid_q <= rx_valid;
      if (ctrl_we & (reg_off_i == OFF_BAUD))
        baud_q <= reg_wdata_i[15:0];
      if (ctrl_we & (reg_off_i == OFF_BREAK))
        u_break_o <= reg_wdata_i[31];
    end
  end

  always_ff @(posedge msoc_clk)
  begin
    if (ctrl_we & (reg_off_i == OFF_TX_BYTE))
      tx_byte_q <= reg_wdata_i[7:0];
  end

  // push once per frame on the rising edge of rx_valid
  assign rx_push_o  = rx_valid & ~rx_valid_q;
  assign rx_entry_o = {rx_err, rx_byte};

  assign status_word = {rx_count_i, rx_almost_full_i, rx_full_i, rx_rderr_i, rx_wrerr_i,
                        rx_head_i[8], tx_busy, rx_busy, 4'b0, ~rx_empty_i, rx_head_i[7:0]};

  always_comb
  begin
    case (reg_off_i)
      OFF_TX_BYTE: ctrl_word = {24'b0, tx_byte_q};
      OFF_BAUD:    ctrl_word = {16'b0, baud_q};
      OFF_BREAK:   ctrl_word = {u_break_o, 31'b0};
      default:     ctrl_word = '0;
    endcase
  end

  assign rdata_o = (reg_region_i == REGION_UART_RX) ? status_word : ctrl_word;

  uart_core uart_core_i (
    .msoc_clk   (msoc_clk),
    .rstn       (rstn),
    .tx_start_i (tx_start_q),
    .tx_byte_i  (tx_byte_q),
    .baud_i     (baud_q),
    .break_i    (u_break_o),
    .rx_i       (uart_rx_i),
    .tx_o       (uart_tx_o),
    .tx_busy_o  (tx_busy),
    .rx_valid_o (rx_valid),
    .rx_byte_o  (rx_byte),
    .rx_err_o   (rx_err),
    .rx_busy_o  (rx_busy)
  );

endmodule

// File: verilog/msoc_bus_bridge.sv
// AXI4-Lite slave bridge for the peripheral regions
// Accepts one write or one read at a time, decodes the region one-hot,
// muxes read data and owns the LED register and the DIP synchronizer.

`timescale 1ns/1ps

module msoc_bus_bridge
  import msoc_periph_pkg::*;
(
  input  logic     msoc_clk,
  input  logic     rstn,
  input  addr_t    s_awaddr_i,
  input  logic     s_awvalid_i,
  output logic     s_awready_o,
  input  data_t    s_wdata_i,
  input  strb_t    s_wstrb_i,
  input  logic     s_wvalid_i,
  output logic     s_wready_o,
  output resp_t    s_bresp_o,
  output logic     s_bvalid_o,
  input  logic     s_bready_i,
  input  addr_t    s_araddr_i,
  input  logic     s_arvalid_i,
  output logic     s_arready_o,
  output data_t    s_rdata_o,
  output resp_t    s_rresp_o,
  output logic     s_rvalid_o,
  input  logic     s_rready_i,
  output logic     reg_we_o,
  output logic     reg_re_o,
  output region_t  reg_region_o,
  output reg_off_t reg_off_o,
  output data_t    reg_wdata_o,
  input  data_t    uart_rdata_i,
  output logic     rx_pop_o,
  output led_t     to_led_o,
  input  dip_t     from_dip_i
);

  logic        wr_accept;
  logic        rd_accept;
  logic        bvalid_q;
  logic        rvalid_q;
  resp_t       bresp_q;
  resp_t       rresp_q;
  data_t       rdata_q;
  region_t     acc_region;
  logic [15:0] region_hit;
  logic        mapped;
  data_t       sel_rdata;
  dip_t        dip_meta;
  dip_t        dip_sync;

  //////////////////////////////////////////////////////////////////////
  // handshakes, write wins a tie

  assign wr_accept   = s_awvalid_i & s_wvalid_i & ~bvalid_q;
  assign rd_accept   = s_arvalid_i & ~rvalid_q & ~wr_accept;
  assign s_awready_o = wr_accept;
  assign s_wready_o  = wr_accept;
  assign s_arready_o = rd_accept;

  assign acc_region = wr_accept ? s_awaddr_i[23:20] : s_araddr_i[23:20];

  always_comb
  begin
    for (int i = 0; i < 16; i++)
    begin
      region_hit[i] = (acc_region == region_t'(i));
    end
  end

  assign mapped = region_hit[REGION_UART_CTRL] | region_hit[REGION_UART_RX] |
                  region_hit[REGION_BOARD];

  // register side
  assign reg_we_o     = wr_accept;
  assign reg_re_o     = rd_accept;
  assign reg_region_o = acc_region;
  assign reg_off_o    = wr_accept ? s_awaddr_i[5:2] : s_araddr_i[5:2];
  assign reg_wdata_o  = s_wdata_i;
  assign rx_pop_o     = wr_accept & region_hit[REGION_UART_RX];  // any write pops

  always_comb
  begin
    sel_rdata = '0;                                  // unmapped reads as zero
    if (region_hit[REGION_BOARD])
      sel_rdata = {16'b0, dip_sync};
    else if (region_hit[REGION_UART_CTRL] | region_hit[REGION_UART_RX])
      sel_rdata = uart_rdata_i;
  end

  //////////////////////////////////////////////////////////////////////
  // response channels and board registers

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
      to_led_o <= '0;
      dip_meta <= '0;
      dip_sync <= '0;
    end
    else
    begin
      if (wr_accept)
        bvalid_q <= 1'b1;
      else if (s_bready_i)
        bvalid_q <= 1'b0;
      if (rd_accept)
        rvalid_q <= 1'b1;
      else if (s_rready_i)
        rvalid_q <= 1'b0;
      if (wr_accept & region_hit[REGION_BOARD] & s_wstrb_i[0])
        to_led_o <= s_wdata_i[7:0];                  // only byte 0 exists
      dip_meta <= from_dip_i;
      dip_sync <= dip_meta;
    end
  end

  always_ff @(posedge msoc_clk)
  begin
    if (wr_accept)
      bresp_q <= mapped ? RESP_OKAY : RESP_SLVERR;
    if (rd_accept)
    begin
      rresp_q <= mapped ? RESP_OKAY : RESP_SLVERR;
      rdata_q <= sel_rdata;
    end
  end

  assign s_bvalid_o = bvalid_q;
  assign s_bresp_o  = bresp_q;
  assign s_rvalid_o = rvalid_q;
  assign s_rresp_o  = rresp_q;
  assign s_rdata_o  = rdata_q;

endmodule

// File: verilog/msoc_periph_top.sv
// Peripheral subsystem top level
// AXI4-Lite bridge, UART register block and receive FIFO.

`timescale 1ns/1ps

module msoc_periph_top
  import msoc_periph_pkg::*;
(
  input  logic  msoc_clk,
  input  logic  rstn,
  input  addr_t s_awaddr_i,
  input  logic  s_awvalid_i,
  output logic  s_awready_o,
  input  data_t s_wdata_i,
  input  strb_t s_wstrb_i,
  input  logic  s_wvalid_i,
  output logic  s_wready_o,
  output resp_t s_bresp_o,
  output logic  s_bvalid_o,
  input  logic  s_bready_i,
  input  addr_t s_araddr_i,
  input  logic  s_arvalid_i,
  output logic  s_arready_o,
  output data_t s_rdata_o,
  output resp_t s_rresp_o,
  output logic  s_rvalid_o,
  input  logic  s_rready_i,
  input  logic  uart_rx_i,
  output logic  uart_tx_o,
  output logic  u_break_o,
  output led_t  to_led_o,
  input  dip_t  from_dip_i
);

  logic      reg_we;
  region_t   reg_region;
  reg_off_t  reg_off;
  data_t     reg_wdata;
  data_t     uart_rdata;
  logic      rx_pop;
  logic      rx_push;
  rx_entry_t rx_entry;
  rx_entry_t rx_head;
  logic      rx_empty;
  logic      rx_full;
  logic      rx_almost_full;
  logic      rx_wrerr;
  logic      rx_rderr;
  fifo_cnt_t rx_count;

  msoc_bus_bridge msoc_bus_bridge_i (
    .msoc_clk     (msoc_clk),
    .rstn         (rstn),
    .s_awaddr_i   (s_awaddr_i),
    .s_awvalid_i  (s_awvalid_i),
    .s_awready_o  (s_awready_o),
    .s_wdata_i    (s_wdata_i),
    .s_wstrb_i    (s_wstrb_i),
    .s_wvalid_i   (s_wvalid_i),
    .s_wready_o   (s_wready_o),
    .s_bresp_o    (s_bresp_o),
    .s_bvalid_o   (s_bvalid_o),
    .s_bready_i   (s_bready_i),
    .s_araddr_i   (s_araddr_i),
    .s_arvalid_i  (s_arvalid_i),
    .s_arready_o  (s_arready_o),
    .s_rdata_o    (s_rdata_o),
    .s_rresp_o    (s_rresp_o),
    .s_rvalid_o   (s_rvalid_o),
    .s_rready_i   (s_rready_i),
    .reg_we_o     (reg_we),
    .reg_re_o     (),                                // reads have no side effects here
    .reg_region_o (reg_region),
    .reg_off_o    (reg_off),
    .reg_wdata_o  (reg_wdata),
    .uart_rdata_i (uart_rdata),
    .rx_pop_o     (rx_pop),
    .to_led_o     (to_led_o),
    .from_dip_i   (from_dip_i)
  );

  uart_regs uart_regs_i (
    .msoc_clk         (msoc_clk),
    .rstn             (rstn),
    .reg_we_i         (reg_we),
    .reg_region_i     (reg_region),
    .reg_off_i        (reg_off),
    .reg_wdata_i      (reg_wdata),
    .rdata_o          (uart_rdata),
    .rx_push_o        (rx_push),
    .rx_entry_o       (rx_entry),
    .rx_head_i        (rx_head),
    .rx_empty_i       (rx_empty),
    .rx_full_i        (rx_full),
    .rx_almost_full_i (rx_almost_full),
    .rx_wrerr_i       (rx_wrerr),
    .rx_rderr_i       (rx_rderr),
    .rx_count_i       (rx_count),
    .uart_rx_i        (uart_rx_i),
    .uart_tx_o        (uart_tx_o),
    .u_break_o        (u_break_o)
  );

  sync_fifo #(
    .DEPTH (RX_FIFO_DEPTH)
  ) rx_fifo_i (
    .msoc_clk      (msoc_clk),
    .rstn          (rstn),
    .push_i        (rx_push),
    .din_i         (rx_entry),
    .pop_i         (rx_pop),
    .dout_o        (rx_head),
    .empty_o       (rx_empty),
    .full_o        (rx_full),
    .almost_full_o (rx_almost_full),
    .count_o       (rx_count),
    .wrerr_o       (rx_wrerr),
    .rderr_o       (rx_rderr)
  );

endmodule

// File: testbench/tb_msoc_periph.sv
// Testbench for the peripheral subsystem
// Drives the AXI4-Lite slave, loops the UART back on itself or injects
// serial frames, and checks every response against a FIFO queue model.

`timescale 1ns/1ps

module tb_msoc_periph
  import msoc_periph_pkg::*;
;

  localparam int TEST_BAUD    = 4;
  localparam int IDLE_BITS    = 2;                       // idle after an injected frame
  localparam int FRAME_CYCLES = (10 + IDLE_BITS) * TEST_BAUD;
  localparam int NUM_FRAMES   = 8 + 1 + 17;
  localparam int SETUP_CYCLES = 400;                     // reset and register tests
  localparam int CYCLE_LIMIT  = NUM_FRAMES * FRAME_CYCLES * 3 / 2 + SETUP_CYCLES;
  localparam int POLL_LIMIT   = 100;
  localparam int HS_LIMIT     = 20;

  logic      msoc_clk;
  logic      rstn;
  addr_t     s_awaddr;
  logic      s_awvalid;
  logic      s_awready;
  data_t     s_wdata;
  strb_t     s_wstrb;
  logic      s_wvalid;
  logic      s_wready;
  resp_t     s_bresp;
  logic      s_bvalid;
  logic      s_bready;
  addr_t     s_araddr;
  logic      s_arvalid;
  logic      s_arready;
  data_t     s_rdata;
  resp_t     s_rresp;
  logic      s_rvalid;
  logic      s_rready;
  logic      uart_rx;
  logic      uart_tx;
  logic      u_break;
  led_t      to_led;
  dip_t      from_dip;
  logic      loopback_en;
  logic      inject_line;
  int        cycle_count;
  logic [15:0] lfsr_q;
  rx_entry_t rx_model[$];                                // expected FIFO contents
  logic      model_wrerr;
  logic      model_rderr;
  led_t      led_model;

  assign uart_rx = loopback_en ? uart_tx : inject_line;

  msoc_periph_top msoc_periph_top_i (
    .msoc_clk    (msoc_clk),
    .rstn        (rstn),
    .s_awaddr_i  (s_awaddr),
    .s_awvalid_i (s_awvalid),
    .s_awready_o (s_awready),
    .s_wdata_i   (s_wdata),
    .s_wstrb_i   (s_wstrb),
    .s_wvalid_i  (s_wvalid),
    .s_wready_o  (s_wready),
    .s_bresp_o   (s_bresp),
    .s_bvalid_o  (s_bvalid),
    .s_bready_i  (s_bready),
    .s_araddr_i  (s_araddr),
    .s_arvalid_i (s_arvalid),
    .s_arready_o (s_arready),
    .s_rdata_o   (s_rdata),
    .s_rresp_o   (s_rresp),
    .s_rvalid_o  (s_rvalid),
    .s_rready_i  (s_rready),
    .uart_rx_i   (uart_rx),
    .uart_tx_o   (uart_tx),
    .u_break_o   (u_break),
    .to_led_o    (to_led),
    .from_dip_i  (from_dip)
  );

  initial msoc_clk = 1'b0;
  always #10 msoc_clk = ~msoc_clk;                       // 20 ns period

  always @(posedge msoc_clk)
  begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT)
      abort_run("timeout: the test sequence did not finish within the cycle limit");
  end

  ////////////////////////////////////////////////////////////////////////
  // helpers

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped");
  endtask

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];                  // x^16+x^14+x^13+x^11
    return {s[14:0], fb};
  endfunction

  task automatic rand_byte(output uart_byte_t b);
    for (int i = 0; i < 8; i++)
    begin
      lfsr_q = lfsr_next(lfsr_q);
      b[i]   = lfsr_q[0];
    end
  endtask

  function automatic addr_t reg_addr(input region_t r, input reg_off_t o);
    return {8'h00, r, 14'h0, o, 2'b00};
  endfunction

  // expected UART status word
  function automatic data_t status_model(input rx_entry_t head, input fifo_cnt_t cnt,
                                         input logic wrerr, input logic rderr);
    data_t w;
    w        = '0;
    w[31:20] = cnt;
    w[19]    = (cnt >= RX_ALMOST_FULL);
    w[18]    = (cnt == fifo_cnt_t'(RX_FIFO_DEPTH));
    w[17]    = rderr;
    w[16]    = wrerr;
    w[15]    = head[8];
    w[8]     = (cnt != '0);
    w[7:0]   = head[7:0];
    return w;                                            // both engines idle
  endfunction

  task automatic check_data(input string name, input data_t got, input data_t exp,
                            input data_t mask);
    if (((got ^ exp) & mask) !== '0)
      abort_run($sformatf("[ERROR] %s: got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_resp(input string name, input resp_t got, input resp_t exp);
    if (got !== exp)
      abort_run($sformatf("[ERROR] %s: got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_led(input string name, input led_t got, input led_t exp);
    if (got !== exp)
      abort_run($sformatf("[ERROR] %s: got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_line(input string name, input logic got, input logic exp);
    if (got !== exp)
      abort_run($sformatf("[ERROR] %s: got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic write_reg(input addr_t addr, input data_t data, input strb_t strb,
                           output resp_t resp);
    int waits;
    waits = 0;
    @(negedge msoc_clk);
    s_awaddr  = addr;
    s_wdata   = data;
    s_wstrb   = strb;
    s_awvalid = 1'b1;
    s_wvalid  = 1'b1;
    do
    begin
      @(negedge msoc_clk);
      waits++;
      if (waits > HS_LIMIT)
        abort_run("write handshake never completed");
    end
    while (!s_bvalid);
    s_awvalid = 1'b0;                                    // bvalid blocks a second accept
    s_wvalid  = 1'b0;
    resp      = s_bresp;
  endtask

  task automatic read_reg(input addr_t addr, output data_t data, output resp_t resp);
    int waits;
    waits = 0;
    @(negedge msoc_clk);
    s_araddr  = addr;
    s_arvalid = 1'b1;
    do
    begin
      @(negedge msoc_clk);
      waits++;
      if (waits > HS_LIMIT)
        abort_run("read handshake never completed");
    end
    while (!s_rvalid);
    s_arvalid = 1'b0;
    data      = s_rdata;
    resp      = s_rresp;
  endtask

  // 8N1 frame on the injected line, stop bit chosen by the caller
  task automatic send_frame(input uart_byte_t b, input logic stop_bit);
    logic [9:0] bits;
    bits = {stop_bit, b, 1'b0};
    for (int i = 0; i < 10; i++)
    begin
      @(negedge msoc_clk);
      inject_line = bits[i];
      repeat (TEST_BAUD - 1) @(negedge msoc_clk);
    end
    @(negedge msoc_clk);
    inject_line = 1'b1;
    repeat (IDLE_BITS * TEST_BAUD - 1) @(negedge msoc_clk);
  endtask

  task automatic model_push(input rx_entry_t e);
    if (rx_model.size() < RX_FIFO_DEPTH)
      rx_model.push_back(e);
    else
      model_wrerr = 1'b1;                                // overflow
  endtask

  task automatic compare_status(input string name, input data_t got);
    rx_entry_t head;
    fifo_cnt_t cnt;
    data_t     mask;
    cnt  = fifo_cnt_t'(rx_model.size());
    head = (rx_model.size() > 0) ? rx_model[0] : '0;
    mask = (cnt == '0) ? 32'hFFFF_7F00 : 32'hFFFF_FFFF; // stale head when empty
    check_data(name, got, status_model(head, cnt, model_wrerr, model_rderr), mask);
  endtask

  task automatic wait_status(input data_t sel, input data_t val, output data_t st);
    int    polls;
    resp_t r;
    polls = 0;
    read_reg(reg_addr(REGION_UART_RX, reg_off_t'(0)), st, r);
    while ((st & sel) != val)
    begin
      polls++;
      if (polls > POLL_LIMIT)
        abort_run("status polling ran too long without the expected bits");
      read_reg(reg_addr(REGION_UART_RX, reg_off_t'(0)), st, r);
    end
    check_resp("status rresp", r, RESP_OKAY);
  endtask

  task automatic pop_rx();
    resp_t r;
    write_reg(reg_addr(REGION_UART_RX, reg_off_t'(0)), '0, 4'hF, r);
    check_resp("pop bresp", r, RESP_OKAY);
    if (rx_model.size() > 0)
      void'(rx_model.pop_front());
    else
      model_rderr = 1'b1;                                // underflow
  endtask

  ////////////////////////////////////////////////////////////////////////
  // test sequence

  initial
  begin
    data_t      rd;
    resp_t      r;
    uart_byte_t b;
    rstn        = 1'b0;
    s_awaddr    = '0;
    s_awvalid   = 1'b0;
    s_wdata     = '0;
    s_wstrb     = '0;
    s_wvalid    = 1'b0;
    s_bready    = 1'b1;
    s_araddr    = '0;
    s_arvalid   = 1'b0;
    s_rready    = 1'b1;
    from_dip    = '0;
    loopback_en = 1'b0;
    inject_line = 1'b1;
    cycle_count = 0;
    lfsr_q      = 16'd47477;
    model_wrerr = 1'b0;
    model_rderr = 1'b0;
    led_model   = '0;
    repeat (5) @(negedge msoc_clk);
    rstn = 1'b1;

    // reset state
    @(negedge msoc_clk);
    check_line("uart_tx_o", uart_tx, 1'b1);
    check_line("u_break_o", u_break, 1'b0);
    check_led("to_led_o", to_led, led_model);
    check_line("s_awready_o", s_awready, 1'b0);
    check_line("s_wready_o", s_wready, 1'b0);
    check_line("s_arready_o", s_arready, 1'b0);
    check_line("s_bvalid_o", s_bvalid, 1'b0);
    check_line("s_rvalid_o", s_rvalid, 1'b0);
    read_reg(reg_addr(REGION_UART_RX, reg_off_t'(0)), rd, r);
    check_resp("status rresp", r, RESP_OKAY);
    compare_status("reset status", rd);

    // board registers, only byte 0 of the LED word exists
    write_reg(reg_addr(REGION_BOARD, reg_off_t'(0)), 32'h0000_00A5, 4'b0001, r);
    check_resp("led bresp", r, RESP_OKAY);
    led_model = 8'hA5;
    check_led("to_led_o", to_led, led_model);
    write_reg(reg_addr(REGION_BOARD, reg_off_t'(0)), 32'h5A5A_5A5A, 4'b1110, r);
    check_led("to_led_o", to_led, led_model);
    @(negedge msoc_clk);
    from_dip = 16'hBEEF;
    repeat (2) @(negedge msoc_clk);
    read_reg(reg_addr(REGION_BOARD, reg_off_t'(0)), rd, r);
    check_resp("dip rresp", r, RESP_OKAY);
    check_data("dip word", rd, {16'h0, from_dip}, 32'hFFFF_FFFF);

    // unmapped region
    write_reg(reg_addr(4'd5, reg_off_t'(0)), 32'h0000_0033, 4'hF, r);
    check_resp("unmapped bresp", r, RESP_SLVERR);
    read_reg(reg_addr(4'd5, reg_off_t'(0)), rd, r);
    check_resp("unmapped rresp", r, RESP_SLVERR);
    check_data("unmapped rdata", rd, '0, 32'hFFFF_FFFF);
    check_led("to_led_o", to_led, led_model);
    read_reg(reg_addr(REGION_UART_RX, reg_off_t'(0)), rd, r);
    compare_status("status after unmapped", rd);

    // loopback at baud 4
    write_reg(reg_addr(REGION_UART_CTRL, OFF_BAUD), 32'd4, 4'hF, r);
    check_resp("baud bresp", r, RESP_OKAY);
    read_reg(reg_addr(REGION_UART_CTRL, OFF_BAUD), rd, r);
    check_data("baud", rd, 32'd4, 32'hFFFF_FFFF);
    @(negedge msoc_clk);
    loopback_en = 1'b1;
    for (int i = 0; i < 8; i++)
    begin
      rand_byte(b);
      write_reg(reg_addr(REGION_UART_CTRL, OFF_TX_BYTE), {24'h0, b}, 4'hF, r);
      check_resp("tx bresp", r, RESP_OKAY);
      model_push({1'b0, b});
      wait_status(32'h0000_6100, 32'h0000_0100, rd);  // not empty, both idle
      compare_status("loopback status", rd);
      pop_rx();
    end
    @(negedge msoc_clk);
    loopback_en = 1'b0;

    // framing error
    send_frame(8'h3C, 1'b0);
    model_push({1'b1, 8'h3C});
    wait_status(32'h0000_6100, 32'h0000_0100, rd);
    compare_status("framing error status", rd);
    pop_rx();

    // overflow, 17 frames without a pop
    for (int i = 0; i < 17; i++)
    begin
      rand_byte(b);
      send_frame(b, 1'b1);
      model_push({1'b0, b});
    end
    wait_status(32'h0000_6000, 32'h0000_0000, rd);
    compare_status("overflow status", rd);

    // break
    write_reg(reg_addr(REGION_UART_CTRL, OFF_BREAK), 32'h8000_0000, 4'hF, r);
    check_resp("break bresp", r, RESP_OKAY);
    repeat (8)
    begin
      check_line("uart_tx_o", uart_tx, 1'b0);
      check_line("u_break_o", u_break, 1'b1);
      @(negedge msoc_clk);
    end
    write_reg(reg_addr(REGION_UART_CTRL, OFF_BREAK), 32'h0000_0000, 4'hF, r);
    check_line("uart_tx_o", uart_tx, 1'b1);
    check_line("u_break_o", u_break, 1'b0);

    $display("Result: PASSED");
    $finish;
  end

endmodule

// File: list.f
verilog/msoc_periph_pkg.sv
verilog/sync_fifo.sv
verilog/uart_core.sv
verilog/uart_regs.sv
verilog/msoc_bus_bridge.sv
verilog/msoc_periph_top.sv
testbench/tb_msoc_periph.sv

// File: Makefile
# Verilator build and run for the peripheral subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_msoc_periph
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides pass or fail, not the simulator exit code
run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
